/* run_sim.sh */
#!/bin/bash
# build and run the stock_program testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stock_program -f stock_program.f -o tb_stock_program \
    && ./obj_dir/tb_stock_program +verilator+error+limit+100 > "$LOG" 2>&1 \
    || { echo "build or simulation did not complete"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "Testbench failed" "$LOG" && exit 1 || exit 0

/* src/order_collector.sv */
`timescale 1ns/1ps

module order_collector (
    input  logic                   clk,
    input  logic                   inf,
    input  logic                   action_valid,
    input  logic                   formula_valid,
    input  logic                   mode_valid,
    input  logic                   date_valid,
    input  logic                   data_no_valid,
    input  logic                   index_valid,
    input  stock_pkg::field_word_u in_data,
    order_if.producer              ord
);
    import stock_pkg::*;

    typedef enum logic [2:0] {
        S_ACTION,
        S_FORMULA,
        S_MODE,
        S_DATE,
        S_DATA_NO,
        S_INDEX
    } field_state_e;

    field_state_e state;
    field_state_e state_nxt;
    logic [1:0]   idx_cnt;
    logic         take_action;
    logic         take_formula;
    logic         take_mode;
    logic         take_date;
    logic         take_data_no;
    logic         take_index;
    logic         last_field;

    // strobes count only in their own slot and never while an order waits
    assign take_action  = !ord.valid && state == S_ACTION  && action_valid;
    assign take_formula = !ord.valid && state == S_FORMULA && formula_valid;
    assign take_mode    = !ord.valid && state == S_MODE    && mode_valid;
    assign take_date    = !ord.valid && state == S_DATE    && date_valid;
    assign take_data_no = !ord.valid && state == S_DATA_NO && data_no_valid;
    assign take_index   = !ord.valid && state == S_INDEX   && index_valid;

    always_comb begin
        state_nxt  = state;
        last_field = 1'b0;
        if (take_action) begin
            // date check skips formula and mode
            if (in_data.act.action == Check_Valid_Date) begin
                state_nxt = S_DATE;
            end else begin
                state_nxt = S_FORMULA;
            end
        end
        if (take_formula) begin
            state_nxt = S_MODE;
        end
        if (take_mode) begin
            state_nxt = S_DATE;
        end
        if (take_date) begin
            state_nxt = S_DATA_NO;
        end
        if (take_data_no) begin
            if (ord.action == Check_Valid_Date) begin
                state_nxt  = S_ACTION;
                last_field = 1'b1;
            end else begin
                state_nxt = S_INDEX;
            end
        end
        if (take_index && idx_cnt == 2'd3) begin
            state_nxt  = S_ACTION;
            last_field = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state     <= S_ACTION;
            idx_cnt   <= 2'd0;
            ord.valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (take_index) begin
                idx_cnt <= idx_cnt + 2'd1;
            end
            if (last_field) begin
                ord.valid <= 1'b1;
            end else if (ord.ready) begin
                ord.valid <= 1'b0;
            end
        end
    end

    // order payload
    always_ff @(posedge clk) begin
        if (take_action) begin
            ord.action <= in_data.act.action;
        end
        if (take_formula) begin
            ord.formula <= in_data.frm.formula;
        end
        if (take_mode) begin
            ord.mode <= in_data.md.mode;
        end
        if (take_date) begin
            ord.today <= in_data.dt.date;
        end
        if (take_data_no) begin
            ord.data_no <= in_data.dno.data_no;
        end
        if (take_index) begin
            ord.idx[idx_cnt] <= in_data.index;
        end
    end

endmodule

/* src/record_store.sv */
`timescale 1ns/1ps
`include "stock_consts.svh"

module record_store (
    input  logic                  clk,
    input  logic                  inf,
    order_if.consumer             ord,
    eval_if.producer              ev,
    input  logic                  wb_valid,
    input  logic [`DATA_NO_W-1:0] wb_data_no,
    input  stock_pkg::record_t    wb_record
);
    import stock_pkg::*;

    record_t                  mem [`RECORD_COUNT];
    logic [`RECORD_COUNT-1:0] written;
    logic                     wb_pending;
    logic                     ord_fire;

    assign ord_fire = ord.valid && ord.ready;

    // an update locks the store until its record comes back
    assign ord.ready = !wb_pending && (!ev.valid || ev.ready);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            ev.valid   <= 1'b0;
            wb_pending <= 1'b0;
            written    <= '0;
        end else begin
            if (ord_fire) begin
                ev.valid <= 1'b1;
            end else if (ev.ready) begin
                ev.valid <= 1'b0;
            end
            if (ord_fire && ord.action == Update) begin
                wb_pending <= 1'b1;
            end else if (wb_valid) begin
                wb_pending <= 1'b0;
            end
            if (wb_valid) begin
                written[wb_data_no] <= 1'b1;
            end
        end
    end

    // =========================================================================
    // record array and eval payload
    // =========================================================================
    always_ff @(posedge clk) begin
        if (ord_fire) begin
            ev.action  <= ord.action;
            ev.formula <= ord.formula;
            ev.mode    <= ord.mode;
            ev.today   <= ord.today;
            ev.data_no <= ord.data_no;
            ev.idx     <= ord.idx;
            // never-written records read as zero
            ev.record  <= written[ord.data_no] ? mem[ord.data_no] : '0;
        end
        if (wb_valid) begin
            mem[wb_data_no] <= wb_record;
        end
    end

endmodule

/* src/risk_evaluator.sv */
`timescale 1ns/1ps
`include "stock_consts.svh"

module risk_evaluator (
    input  logic                  clk,
    input  logic                  inf,
    eval_if.consumer              ev,
    output logic                  wb_valid,
    output logic [`DATA_NO_W-1:0] wb_data_no,
    output stock_pkg::record_t    wb_record,
    output logic                  out_valid,
    output stock_pkg::warn_e      warn_msg,
    output logic                  complete
);
    import stock_pkg::*;

    // accepted order and record
    action_e                  act;
    formula_e                 formula;
    mode_e                    mode;
    date_t                    today;
    logic [`DATA_NO_W-1:0]    data_no;
    logic [3:0][`IDX_W-1:0]   in_idx;
    record_t                  rec;

    logic                     busy;
    logic [1:0]               step;
    logic                     last_step;
    logic                     res_valid;
    warn_e                    warn_nxt;
    warn_e                    warn_r;

    logic [3:0][`IDX_W-1:0]   gap;
    logic [3:0][`IDX_W-1:0]   pair;
    logic [`IDX_W-1:0]        top;
    logic [`IDX_W-1:0]        bot;
    logic [`IDX_W+1:0]        sum_rec;
    logic [`IDX_W+1:0]        sum_gap;
    logic [2:0]               cnt_mid;
    logic [2:0]               cnt_ge;
    logic [`IDX_W-1:0]        r_nxt;
    logic [`IDX_W-1:0]        r_val;
    logic [`IDX_W-1:0]        threshold;
    logic                     date_warn;

    logic signed [`IDX_W+1:0] upd_sum [4];
    logic [3:0][`IDX_W-1:0]   upd_idx;
    logic                     upd_clamped;

    assign ev.ready   = !busy;
    assign wb_data_no = data_no;

    // index check needs three compute cycles, the others one
    assign last_step = (act == Index_Check) ? (step == 2'd2) : (step == 2'd0);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            busy      <= 1'b0;
            step      <= 2'd0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= busy && last_step;
            if (ev.valid && ev.ready) begin
                busy <= 1'b1;
                step <= 2'd0;
            end else if (res_valid) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ev.valid && ev.ready) begin
            act     <= ev.action;
            formula <= ev.formula;
            mode    <= ev.mode;
            today   <= ev.today;
            data_no <= ev.data_no;
            in_idx  <= ev.idx;
            rec     <= ev.record;
        end
    end

    // =========================================================================
    // index check pipeline
    // =========================================================================
    // stage 1: gaps and first compare layer
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rec.idx[i] >= in_idx[i]) begin
                gap[i] <= rec.idx[i] - in_idx[i];
            end else begin
                gap[i] <= in_idx[i] - rec.idx[i];
            end
        end
        for (int j = 0; j < 2; j++) begin
            if (rec.idx[2*j] >= rec.idx[2*j+1]) begin
                pair[2*j]   <= rec.idx[2*j];
                pair[2*j+1] <= rec.idx[2*j+1];
            end else begin
                pair[2*j]   <= rec.idx[2*j+1];
                pair[2*j+1] <= rec.idx[2*j];
            end
        end
    end

    // stage 2: only the two ends of the order are needed
    assign top = (pair[0] >= pair[2]) ? pair[0] : pair[2];
    assign bot = (pair[1] <= pair[3]) ? pair[1] : pair[3];

    always_comb begin
        sum_rec = '0;
        sum_gap = '0;
        cnt_mid = 3'd0;
        cnt_ge  = 3'd0;
        for (int i = 0; i < 4; i++) begin
            sum_rec = sum_rec + {2'b00, rec.idx[i]};
            sum_gap = sum_gap + {2'b00, gap[i]};
            cnt_mid = cnt_mid + {2'b00, rec.idx[i] >= `MID_LEVEL};
            cnt_ge  = cnt_ge + {2'b00, rec.idx[i] >= in_idx[i]};
        end
        case (formula)
            Formula_A: r_nxt = sum_rec[`IDX_W+1:2];
            Formula_B: r_nxt = top - bot;
            Formula_C: r_nxt = bot;
            Formula_D: r_nxt = {{(`IDX_W-3){1'b0}}, cnt_mid};
            Formula_E: r_nxt = {{(`IDX_W-3){1'b0}}, cnt_ge};
            Formula_H: r_nxt = sum_gap[`IDX_W+1:2];
            default:   r_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        r_val <= r_nxt;
    end

    always_comb begin
        case (formula)
            Formula_A, Formula_C: begin
                case (mode)
                    Insensitive: threshold = `TH_AC_INS;
                    Normal:      threshold = `TH_AC_NOR;
                    default:     threshold = `TH_AC_SEN;
                endcase
            end
            Formula_D, Formula_E: begin
                case (mode)
                    Insensitive: threshold = `TH_DE_INS;
                    Normal:      threshold = `TH_DE_NOR;
                    default:     threshold = `TH_DE_SEN;
                endcase
            end
            default: begin
                case (mode)
                    Insensitive: threshold = `TH_BH_INS;
                    Normal:      threshold = `TH_BH_NOR;
                    default:     threshold = `TH_BH_SEN;
                endcase
            end
        endcase
    end

    // =========================================================================
    // update, date check and result
    // =========================================================================
    always_comb begin
        upd_clamped = 1'b0;
        for (int i = 0; i < 4; i++) begin
            upd_sum[i] = $signed({2'b00, rec.idx[i]}) +
                         $signed({{2{in_idx[i][`IDX_W-1]}}, in_idx[i]});
            if (upd_sum[i][`IDX_W+1]) begin
                upd_idx[i]  = '0;
                upd_clamped = 1'b1;
            end else if (upd_sum[i][`IDX_W]) begin
                upd_idx[i]  = `IDX_MAX;
                upd_clamped = 1'b1;
            end else begin
                upd_idx[i] = upd_sum[i][`IDX_W-1:0];
            end
        end
    end

    assign date_warn = (today.month < rec.date.month) ||
                       (today.month == rec.date.month && today.day < rec.date.day);

    // date warning wins over risk
    always_comb begin
        case (act)
            Index_Check: begin
                if (date_warn) begin
                    warn_nxt = Date_Warn;
                end else if (r_val >= threshold) begin
                    warn_nxt = Risk_Warn;
                end else begin
                    warn_nxt = No_Warn;
                end
            end
            Update:  warn_nxt = upd_clamped ? Data_Warn : No_Warn;
            default: warn_nxt = date_warn ? Date_Warn : No_Warn;
        endcase
    end

    always_ff @(posedge clk) begin
        warn_r         <= warn_nxt;
        wb_record.idx  <= upd_idx;
        wb_record.date <= today;
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            out_valid <= 1'b0;
            warn_msg  <= No_Warn;
            complete  <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            out_valid <= res_valid;
            warn_msg  <= res_valid ? warn_r : No_Warn;
            complete  <= res_valid && warn_r == No_Warn;
            wb_valid  <= res_valid && act == Update;
        end
    end

endmodule

/* src/stock_consts.svh */
`ifndef STOCK_CONSTS_SVH
`define STOCK_CONSTS_SVH

// field and storage sizes
`define IDX_W        12
`define IDX_MAX      12'd4095
`define DATA_NO_W    8
`define RECORD_COUNT 256

// formula d counts indices at or above this level
`define MID_LEVEL    12'd2047

// formulas a and c
`define TH_AC_INS    12'd2047
`define TH_AC_NOR    12'd1023
`define TH_AC_SEN    12'd511

// formulas b and h
`define TH_BH_INS    12'd800
`define TH_BH_NOR    12'd400
`define TH_BH_SEN    12'd200

// formulas d and e
`define TH_DE_INS    12'd3
`define TH_DE_NOR    12'd2
`define TH_DE_SEN    12'd1

`endif

/* src/stock_if.sv */
`timescale 1ns/1ps
`include "stock_consts.svh"

// collected order, collector to store
interface order_if;
    import stock_pkg::*;

    logic                   valid;
    logic                   ready;
    action_e                action;
    formula_e               formula;
    mode_e                  mode;
    date_t                  today;
    logic [`DATA_NO_W-1:0]  data_no;
    logic [3:0][`IDX_W-1:0] idx;

    modport producer (
        output valid, action, formula, mode, today, data_no, idx,
        input  ready
    );

    modport consumer (
        input  valid, action, formula, mode, today, data_no, idx,
        output ready
    );
endinterface

// order plus its stored record, store to evaluator
interface eval_if;
    import stock_pkg::*;

    logic                   valid;
    logic                   ready;
    action_e                action;
    formula_e               formula;
    mode_e                  mode;
    date_t                  today;
    logic [`DATA_NO_W-1:0]  data_no;
    logic [3:0][`IDX_W-1:0] idx;
    record_t                record;

    modport producer (
        output valid, action, formula, mode, today, data_no, idx, record,
        input  ready
    );

    modport consumer (
        input  valid, action, formula, mode, today, data_no, idx, record,
        output ready
    );
endinterface

/* src/stock_pkg.sv */
`include "stock_consts.svh"

package stock_pkg;

    typedef enum logic [1:0] {
        Index_Check      = 2'd0,
        Update           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_e;

    // codes 5 and 6 are reserved
    typedef enum logic [2:0] {
        Formula_A = 3'd0,
        Formula_B = 3'd1,
        Formula_C = 3'd2,
        Formula_D = 3'd3,
        Formula_E = 3'd4,
        Formula_F = 3'd5,
        Formula_G = 3'd6,
        Formula_H = 3'd7
    } formula_e;

    typedef enum logic [1:0] {
        Insensitive = 2'd0,
        Normal      = 2'd1,
        Sensitive   = 2'd3
    } mode_e;

    typedef enum logic [1:0] {
        No_Warn   = 2'd0,
        Date_Warn = 2'd1,
        Risk_Warn = 2'd2,
        Data_Warn = 2'd3
    } warn_e;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    typedef struct packed {
        logic [3:0][`IDX_W-1:0] idx;
        date_t                  date;
    } record_t;

    // one input word, read by whichever strobe is high
    typedef union packed {
        struct packed { logic [`IDX_W-3:0] rsv; action_e action; } act;
        struct packed { logic [`IDX_W-4:0] rsv; formula_e formula; } frm;
        struct packed { logic [`IDX_W-3:0] rsv; mode_e mode; } md;
        struct packed { logic [`IDX_W-10:0] rsv; date_t date; } dt;
        struct packed {
            logic [`IDX_W-`DATA_NO_W-1:0] rsv;
            logic [`DATA_NO_W-1:0]        data_no;
        } dno;
        logic [`IDX_W-1:0] index;
    } field_word_u;

endpackage

/* src/stock_program.sv */
`timescale 1ns/1ps
`include "stock_consts.svh"

module stock_program (
    input  logic               clk,
    input  logic               inf,
    input  logic               action_valid,
    input  logic               formula_valid,
    input  logic               mode_valid,
    input  logic               date_valid,
    input  logic               data_no_valid,
    input  logic               index_valid,
    input  logic [`IDX_W-1:0]  in_data,
    output logic               out_valid,
    output stock_pkg::warn_e   warn_msg,
    output logic               complete
);
    import stock_pkg::*;

    // write-back path, evaluator to store
    logic                  wb_valid;
    logic [`DATA_NO_W-1:0] wb_data_no;
    record_t               wb_record;

    order_if ord_bus ();
    eval_if  ev_bus ();

    order_collector u_collector (
        .clk           (clk),
        .inf           (inf),
        .action_valid  (action_valid),
        .formula_valid (formula_valid),
        .mode_valid    (mode_valid),
        .date_valid    (date_valid),
        .data_no_valid (data_no_valid),
        .index_valid   (index_valid),
        .in_data       (in_data),
        .ord           (ord_bus.producer)
    );

    record_store u_store (
        .clk        (clk),
        .inf        (inf),
        .ord        (ord_bus.consumer),
        .ev         (ev_bus.producer),
        .wb_valid   (wb_valid),
        .wb_data_no (wb_data_no),
        .wb_record  (wb_record)
    );

    risk_evaluator u_evaluator (
        .clk        (clk),
        .inf        (inf),
        .ev         (ev_bus.consumer),
        .wb_valid   (wb_valid),
        .wb_data_no (wb_data_no),
        .wb_record  (wb_record),
        .out_valid  (out_valid),
        .warn_msg   (warn_msg),
        .complete   (complete)
    );

endmodule

/* stock_program.f */
+incdir+src
src/stock_pkg.sv
src/stock_if.sv
src/order_collector.sv
src/record_store.sv
src/risk_evaluator.sv
src/stock_program.sv
test/stock_program_sva.sv
test/tb_stock_program.sv

/* test/stock_golden.txt */
# all columns hex: action formula mode month day data_no idx0 idx1 idx2 idx3 warn complete
# action 0 index check, 1 update, 2 date check; warn 0 none, 1 date, 2 risk, 3 data
2 0 0 1 01 05 000 000 000 000 0 1
1 0 0 3 0a 01 064 0c8 12c 190 0 1
1 0 0 3 0a 02 7d0 3e8 5dc 0c8 0 1
1 0 0 4 0f 02 7d0 000 000 000 0 1
1 0 0 5 01 03 7ff 7ff 7ff 7ff 0 1
1 0 0 5 01 03 7ff 7ff 7ff 7ff 0 1
1 0 0 5 01 03 7ff 7ff 7ff 7ff 3 0
1 0 0 5 01 04 064 064 064 064 0 1
1 0 0 5 01 04 f9c f38 000 001 3 0
0 2 0 6 14 03 000 000 000 000 2 0
0 4 0 6 14 03 fff fff fff fff 2 0
0 7 3 6 14 04 000 000 000 000 0 1
0 0 0 6 14 02 000 000 000 000 0 1
0 0 1 6 14 02 000 000 000 000 2 0
0 0 3 6 14 02 000 000 000 000 2 0
0 1 0 6 14 01 000 000 000 000 0 1
0 1 1 6 14 01 000 000 000 000 0 1
0 1 3 6 14 01 000 000 000 000 2 0
0 2 1 6 14 02 000 000 000 000 0 1
0 2 3 6 14 01 000 000 000 000 0 1
0 3 0 6 14 02 000 000 000 000 0 1
0 3 1 6 14 02 000 000 000 000 0 1
0 3 3 6 14 02 000 000 000 000 2 0
0 4 0 6 14 01 064 0c8 12c 191 2 0
0 4 1 6 14 01 065 0c8 12d 191 0 1
0 4 3 6 14 01 065 0c8 12d 191 2 0
0 7 0 6 14 02 000 3e8 5dc 0c8 2 0
0 7 1 6 14 01 000 000 000 000 0 1
0 1 0 4 0e 02 000 000 000 000 1 0
0 0 0 3 14 02 000 000 000 000 1 0
0 1 0 4 0f 02 000 000 000 000 2 0
2 0 0 4 0e 02 000 000 000 000 1 0
2 0 0 4 0f 02 000 000 000 000 0 1
2 0 0 2 1c 01 000 000 000 000 1 0

/* test/stock_program_sva.sv */
`timescale 1ns/1ps

module stock_program_sva (
    input logic             clk,
    input logic             inf,
    input logic             out_valid,
    input stock_pkg::warn_e warn_msg,
    input logic             complete,
    input logic             wb_valid
);
    import stock_pkg::*;

    // result strobe lasts one cycle
    property p_single_pulse;
        @(posedge clk) disable iff (!inf) out_valid |=> !out_valid;
    endproperty

    property p_complete_no_warn;
        @(posedge clk) disable iff (!inf) complete |-> out_valid && warn_msg == No_Warn;
    endproperty

    property p_no_warn_complete;
        @(posedge clk) disable iff (!inf) out_valid && warn_msg == No_Warn |-> complete;
    endproperty

    // quiet outputs between results
    property p_idle_outputs;
        @(posedge clk) disable iff (!inf) !out_valid |-> warn_msg == No_Warn && !complete;
    endproperty

    // write-back only alongside an update result
    property p_wb_with_result;
        @(posedge clk) disable iff (!inf) wb_valid |-> out_valid;
    endproperty

    a_single_pulse:     assert property (p_single_pulse)
        else $error("out_valid high for more than one cycle");
    a_complete_no_warn: assert property (p_complete_no_warn)
        else $error("complete set without a No_Warn result");
    a_no_warn_complete: assert property (p_no_warn_complete)
        else $error("No_Warn result without complete");
    a_idle_outputs:     assert property (p_idle_outputs)
        else $error("warn_msg or complete active while out_valid is low");
    a_wb_with_result:   assert property (p_wb_with_result)
        else $error("write-back issued without a result");

endmodule

bind stock_program stock_program_sva u_sva (
    .clk       (clk),
    .inf       (inf),
    .out_valid (out_valid),
    .warn_msg  (warn_msg),
    .complete  (complete),
    .wb_valid  (wb_valid)
);

/* test/tb_stock_program.sv */
`timescale 1ns/1ps
`include "stock_consts.svh"

module tb_stock_program;
    import stock_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int CYCLES_PER_CMD = 50;

    // strobe selectors for the field driver
    localparam int F_ACTION  = 0;
    localparam int F_FORMULA = 1;
    localparam int F_MODE    = 2;
    localparam int F_DATE    = 3;
    localparam int F_DATA_NO = 4;
    localparam int F_INDEX   = 5;

    typedef struct {
        logic [1:0]            action;
        logic [2:0]            formula;
        logic [1:0]            mode;
        logic [3:0]            month;
        logic [4:0]            day;
        logic [`DATA_NO_W-1:0] data_no;
        logic [`IDX_W-1:0]     idx [4];
        logic [1:0]            warn;
        logic                  complete;
    } command_t;

    logic              clk;
    logic              inf;
    logic              action_valid;
    logic              formula_valid;
    logic              mode_valid;
    logic              date_valid;
    logic              data_no_valid;
    logic              index_valid;
    logic [`IDX_W-1:0] in_data;
    logic              out_valid;
    warn_e             warn_msg;
    logic              complete;

    command_t cmds [$];
    int       cycle_count     = 0;
    int       cycle_limit     = 0;
    int       pulse_count     = 0;
    int       protocol_errors = 0;
    int       pass_count      = 0;
    int       fail_count      = 0;
    logic     prev_out_valid  = 1'b0;

    stock_program UUT (
        .clk           (clk),
        .inf           (inf),
        .action_valid  (action_valid),
        .formula_valid (formula_valid),
        .mode_valid    (mode_valid),
        .date_valid    (date_valid),
        .data_no_valid (data_no_valid),
        .index_valid   (index_valid),
        .in_data       (in_data),
        .out_valid     (out_valid),
        .warn_msg      (warn_msg),
        .complete      (complete)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // output protocol, sampled before the edge updates it
    always @(posedge clk) begin
        if (!out_valid) begin
            assert (warn_msg == No_Warn && complete == 1'b0) else begin
                $display("error: idle outputs warn_msg got 0x%h complete got 0x%h, expected 0x0",
                         warn_msg, complete);
                protocol_errors++;
            end
        end
        if (out_valid) begin
            pulse_count++;
            assert (!prev_out_valid) else begin
                $display("out_valid stayed high for more than one cycle");
                protocol_errors++;
            end
        end
        prev_out_valid <= out_valid;
    end

    // =========================================================================
    // golden file and field driver
    // =========================================================================
    task automatic load_commands();
        int       fd;
        int       n;
        string    line;
        int       a, f, m, mo, dy, dn;
        int       x0, x1, x2, x3, w, c;
        command_t cmd;
        fd = $fopen("test/stock_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open test/stock_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                a, f, m, mo, dy, dn, x0, x1, x2, x3, w, c);
                    if (n == 12) begin
                        cmd.action   = a[1:0];
                        cmd.formula  = f[2:0];
                        cmd.mode     = m[1:0];
                        cmd.month    = mo[3:0];
                        cmd.day      = dy[4:0];
                        cmd.data_no  = dn[`DATA_NO_W-1:0];
                        cmd.idx[0]   = x0[`IDX_W-1:0];
                        cmd.idx[1]   = x1[`IDX_W-1:0];
                        cmd.idx[2]   = x2[`IDX_W-1:0];
                        cmd.idx[3]   = x3[`IDX_W-1:0];
                        cmd.warn     = w[1:0];
                        cmd.complete = c[0];
                        cmds.push_back(cmd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one strobe for one cycle, called on a falling edge
    task automatic pulse_field(input int sel, input logic [`IDX_W-1:0] word);
        in_data = word;
        case (sel)
            F_ACTION:  action_valid  = 1'b1;
            F_FORMULA: formula_valid = 1'b1;
            F_MODE:    mode_valid    = 1'b1;
            F_DATE:    date_valid    = 1'b1;
            F_DATA_NO: data_no_valid = 1'b1;
            default:   index_valid   = 1'b1;
        endcase
        @(negedge clk);
        action_valid  = 1'b0;
        formula_valid = 1'b0;
        mode_valid    = 1'b0;
        date_valid    = 1'b0;
        data_no_valid = 1'b0;
        index_valid   = 1'b0;
        in_data       = '0;
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) @(negedge clk);
    endtask

    task automatic run_command(input int n);
        command_t c;
        bit       ok;
        int       lat;
        int       exp_lat;
        c  = cmds[n];
        ok = 1'b1;
        pulse_field(F_ACTION, {10'd0, c.action});
        // date checks carry no formula, mode or indices
        if (c.action != Check_Valid_Date) begin
            idle_gap();
            pulse_field(F_FORMULA, {9'd0, c.formula});
            idle_gap();
            pulse_field(F_MODE, {10'd0, c.mode});
        end
        idle_gap();
        pulse_field(F_DATE, {3'd0, c.month, c.day});
        idle_gap();
        pulse_field(F_DATA_NO, {4'd0, c.data_no});
        if (c.action != Check_Valid_Date) begin
            for (int k = 0; k < 4; k++) begin
                idle_gap();
                pulse_field(F_INDEX, c.idx[k]);
            end
        end
        assert (pulse_count == n) else begin
            $display("out_valid pulsed %0d times before command %0d, expected %0d",
                     pulse_count, n, n);
            ok = 1'b0;
        end
        lat = 0;
        while (!out_valid) begin
            @(negedge clk);
            lat++;
        end
        exp_lat = (c.action == Index_Check) ? 6 : 4;
        assert (warn_msg == c.warn) else begin
            $display("error: warn_msg got 0x%h, expected 0x%h", warn_msg, c.warn);
            ok = 1'b0;
        end
        assert (complete == c.complete) else begin
            $display("error: complete got 0x%h, expected 0x%h", complete, c.complete);
            ok = 1'b0;
        end
        assert (lat == exp_lat) else begin
            $display("result of command %0d came %0d cycles after its last field, not %0d",
                     n, lat, exp_lat);
            ok = 1'b0;
        end
        $display("command %0d action %0d record 0x%h warn_msg 0x%h complete %0d latency %0d %s",
                 n, c.action, c.data_no, warn_msg, complete, lat, ok ? "ok" : "mismatch");
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // =========================================================================
    // main sequence
    // =========================================================================
    initial begin
        inf           = 1'b0;
        action_valid  = 1'b0;
        formula_valid = 1'b0;
        mode_valid    = 1'b0;
        date_valid    = 1'b0;
        data_no_valid = 1'b0;
        index_valid   = 1'b0;
        in_data       = '0;
        void'($urandom(32'he1652346));
        load_commands();
        if (cmds.size() == 0) begin
            $display("no commands were read from test/stock_golden.txt");
            $display("Testbench failed");
        end else begin
            cycle_limit = cmds.size() * CYCLES_PER_CMD + RESET_CYCLES;
            repeat (RESET_CYCLES) @(negedge clk);
            inf = 1'b1;
            for (int i = 0; i < cmds.size(); i++) begin
                run_command(i);
            end
            repeat (2) @(negedge clk);
            assert (pulse_count == cmds.size()) else begin
                $display("out_valid pulsed %0d times for %0d commands",
                         pulse_count, cmds.size());
                protocol_errors++;
            end
            $display("summary: %0d commands, %0d passed, %0d failed, %0d protocol errors",
                     cmds.size(), pass_count, fail_count, protocol_errors);
            if (fail_count == 0 && protocol_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
        end
        $finish;
    end

endmodule
